//--- all.f
logic/isaPkg.sv
logic/coreCfgPkg.sv
logic/aluUnit.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memWritebackStage.sv
logic/cpuCore.sv
verif/clockGen.sv
verif/cpuCoreProperties.sv
verif/cpuCoreTb.sv

//--- logic/aluUnit.sv
/* ALU: add, sub, and, or, shifts, with not-equal and signed less-than flags */
`timescale 1ns/1ps
`default_nettype none

module aluUnit
    import isaPkg::*, coreCfgPkg::*;
(
    input  logic [dataWidth-1:0] operandA,
    input  logic [dataWidth-1:0] operandB,
    input  logic [4:0]           aluOp,
    input  logic [4:0]           shamt,
    output logic [dataWidth-1:0] result,
    output logic                 notEqual,
    output logic                 lessThan
);

    logic [dataWidth-1:0] diff;
    logic                 subOverflow;

    // Flags come off the subtractor whatever aluOp is
    assign diff = operandA - operandB;

    // Signs differ and the difference flips away from A
    assign subOverflow = (operandA[dataWidth-1] ^ operandB[dataWidth-1])
                         & (diff[dataWidth-1] ^ operandA[dataWidth-1]);

    assign notEqual = |diff;
    // True sign of A-B even on overflow
    assign lessThan = diff[dataWidth-1] ^ subOverflow;

    always_comb begin
        case (aluOp)
            aluAdd:  result = operandA + operandB;
            aluSub:  result = diff;
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            aluSll:  result = operandA << shamt;
            // Arithmetic shift keeps the sign
            aluSra:  result = $unsigned($signed(operandA) >>> shamt);
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/coreCfgPkg.sv
/* Core configuration: word, register index and fetch address widths, reset PC */
`default_nettype none

package coreCfgPkg;

    // Machine word
    localparam int dataWidth = 32;

    // 32 architectural registers
    localparam int regIdxWidth = 5;

    // Only the low PC bits reach instruction memory
    localparam int imemAddrWidth = 12;

    // First fetch address
    localparam logic [dataWidth-1:0] resetPc = '0;

endpackage

`default_nettype wire

//--- logic/cpuCore.sv
/* Core top: fetch, decode, execute and memory/writeback stages wired to
   the external instruction memory, data memory and register file */
`timescale 1ns/1ps
`default_nettype none

module cpuCore
    import isaPkg::*, coreCfgPkg::*;
(
    input  logic                     clock,
    input  logic                     rstN,
    output logic [imemAddrWidth-1:0] imemAddr,
    input  logic [dataWidth-1:0]     imemData,
    output logic [dataWidth-1:0]     dmemAddr,
    output logic [dataWidth-1:0]     dmemWriteData,
    output logic                     dmemWriteEn,
    input  logic [dataWidth-1:0]     dmemReadData,
    output logic                     regWriteEn,
    output logic [regIdxWidth-1:0]   regWriteIdx,
    output logic [dataWidth-1:0]     regWriteData,
    output logic [regIdxWidth-1:0]   regReadIdxA,
    output logic [regIdxWidth-1:0]   regReadIdxB,
    input  logic [dataWidth-1:0]     regReadDataA,
    input  logic [dataWidth-1:0]     regReadDataB
);

    ////////////////////////////////////////
    // Inter-stage signals
    ////////////////////////////////////////

    // FD latch
    instrWordU              fdInstr;
    logic [dataWidth-1:0]   fdPcNext;

    // DX latch
    instrWordU              dxInstr;
    logic [dataWidth-1:0]   dxPcNext;
    logic [dataWidth-1:0]   dxRegA;
    logic [dataWidth-1:0]   dxRegB;

    // XM latch
    instrWordU              xmInstr;
    logic [dataWidth-1:0]   xmResult;
    logic [dataWidth-1:0]   xmStoreData;

    // Hazard and control flow
    logic                   loadUseHold;
    logic                   redirect;
    logic [dataWidth-1:0]   redirectPc;

    fetchStage fetch (
        .clock       (clock),
        .rstN        (rstN),
        .imemData    (imemData),
        .loadUseHold (loadUseHold),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .imemAddr    (imemAddr),
        .fdInstr     (fdInstr),
        .fdPcNext    (fdPcNext)
    );

    decodeStage decode (
        .clock        (clock),
        .rstN         (rstN),
        .fdInstr      (fdInstr),
        .fdPcNext     (fdPcNext),
        .regReadDataA (regReadDataA),
        .regReadDataB (regReadDataB),
        .redirect     (redirect),
        .regReadIdxA  (regReadIdxA),
        .regReadIdxB  (regReadIdxB),
        .loadUseHold  (loadUseHold),
        .dxInstr      (dxInstr),
        .dxPcNext     (dxPcNext),
        .dxRegA       (dxRegA),
        .dxRegB       (dxRegB)
    );

    // Writeback outputs double as the MW bypass source
    executeStage execute (
        .clock        (clock),
        .rstN         (rstN),
        .dxInstr      (dxInstr),
        .dxPcNext     (dxPcNext),
        .dxRegA       (dxRegA),
        .dxRegB       (dxRegB),
        .regWriteEn   (regWriteEn),
        .regWriteIdx  (regWriteIdx),
        .regWriteData (regWriteData),
        .redirect     (redirect),
        .redirectPc   (redirectPc),
        .xmInstr      (xmInstr),
        .xmResult     (xmResult),
        .xmStoreData  (xmStoreData)
    );

    memWritebackStage memWb (
        .clock         (clock),
        .rstN          (rstN),
        .xmInstr       (xmInstr),
        .xmResult      (xmResult),
        .xmStoreData   (xmStoreData),
        .dmemReadData  (dmemReadData),
        .dmemAddr      (dmemAddr),
        .dmemWriteData (dmemWriteData),
        .dmemWriteEn   (dmemWriteEn),
        .regWriteEn    (regWriteEn),
        .regWriteIdx   (regWriteIdx),
        .regWriteData  (regWriteData)
    );

endmodule

`default_nettype wire

//--- logic/decodeStage.sv
/* Decode stage: register read index selection, load-use detection
   and the DX latch */
`timescale 1ns/1ps
`default_nettype none

module decodeStage
    import isaPkg::*, coreCfgPkg::*;
(
    input  logic                   clock,
    input  logic                   rstN,
    input  instrWordU              fdInstr,
    input  logic [dataWidth-1:0]   fdPcNext,
    input  logic [dataWidth-1:0]   regReadDataA,
    input  logic [dataWidth-1:0]   regReadDataB,
    input  logic                   redirect,
    output logic [regIdxWidth-1:0] regReadIdxA,
    output logic [regIdxWidth-1:0] regReadIdxB,
    output logic                   loadUseHold,
    output instrWordU              dxInstr,
    output logic [dataWidth-1:0]   dxPcNext,
    output logic [dataWidth-1:0]   dxRegA,
    output logic [dataWidth-1:0]   dxRegB
);

    logic [regIdxWidth-1:0] loadDest;
    logic                   hitA;
    logic                   hitB;

    // Port A is always rs
    assign regReadIdxA = fdInstr.rView.rs;
    // Branches, jr and sw compare or consume rd
    assign regReadIdxB = readsRdAsB(fdInstr.rView.opcode) ? fdInstr.rView.rd
                                                          : fdInstr.rView.rt;

    ////////////////////////////////////////
    // Load-use hazard
    ////////////////////////////////////////

    // Load sitting in execute, data not ready until after memory
    assign loadDest = dxInstr.iView.rd;
    assign hitA     = (regReadIdxA == loadDest);
    // sw store data gets it later through the MW bypass
    assign hitB     = (regReadIdxB == loadDest) && (fdInstr.rView.opcode != opSw);

    assign loadUseHold = (dxInstr.iView.opcode == opLw) && (loadDest != regZero)
                         && (hitA || hitB);

    // Bubble on squash or on the hold cycle
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            dxInstr <= nopWord;
        end else if (redirect || loadUseHold) begin
            dxInstr <= nopWord;
        end else begin
            dxInstr <= fdInstr;
        end
    end

    // Operand values as read, bypass happens in execute
    always_ff @(posedge clock) begin
        dxPcNext <= fdPcNext;
        dxRegA   <= regReadDataA;
        dxRegB   <= regReadDataB;
    end

endmodule

`default_nettype wire

//--- logic/executeStage.sv
/* Execute stage: operand bypass, operand selection, branch and jump
   resolution, and the XM latch */
`timescale 1ns/1ps
`default_nettype none

module executeStage
    import isaPkg::*, coreCfgPkg::*;
(
    input  logic                   clock,
    input  logic                   rstN,
    input  instrWordU              dxInstr,
    input  logic [dataWidth-1:0]   dxPcNext,
    input  logic [dataWidth-1:0]   dxRegA,
    input  logic [dataWidth-1:0]   dxRegB,
    input  logic                   regWriteEn,
    input  logic [regIdxWidth-1:0] regWriteIdx,
    input  logic [dataWidth-1:0]   regWriteData,
    output logic                   redirect,
    output logic [dataWidth-1:0]   redirectPc,
    output instrWordU              xmInstr,
    output logic [dataWidth-1:0]   xmResult,
    output logic [dataWidth-1:0]   xmStoreData
);

    logic [4:0]             opcode;
    logic                   isImm;
    logic                   isBlt;
    logic                   takeBranch;
    logic [regIdxWidth-1:0] idxA;
    logic [regIdxWidth-1:0] idxB;
    logic [regIdxWidth-1:0] xmDest;
    logic                   xmFwd;
    logic [dataWidth-1:0]   valA;
    logic [dataWidth-1:0]   valB;
    logic [dataWidth-1:0]   immExt;
    logic [dataWidth-1:0]   opA;
    logic [dataWidth-1:0]   opB;
    logic [4:0]             aluOpSel;
    logic [dataWidth-1:0]   aluResult;
    logic                   notEqual;
    logic                   lessThan;
    logic [dataWidth-1:0]   branchTarget;
    logic [dataWidth-1:0]   jumpTarget;

    assign opcode = dxInstr.rView.opcode;
    assign isImm  = opcode inside {opAddi, opLw, opSw};
    assign isBlt  = (opcode == opBlt);

    // Same index choice as decode made for the read ports
    assign idxA = dxInstr.rView.rs;
    assign idxB = readsRdAsB(opcode) ? dxInstr.rView.rd : dxInstr.rView.rt;

    ////////////////////////////////////////
    // Bypass network
    ////////////////////////////////////////

    // A load in XM only has its address here, the hold keeps consumers away
    assign xmDest = destReg(xmInstr);
    assign xmFwd  = writesReg(xmInstr.rView.opcode) && (xmInstr.rView.opcode != opLw)
                    && (xmDest != regZero);

    // Youngest producer first
    function automatic logic [dataWidth-1:0] bypass(input logic [regIdxWidth-1:0] idx,
                                                    input logic [dataWidth-1:0] fileVal);
        if (xmFwd && (xmDest == idx)) begin
            return xmResult;
        end else if (regWriteEn && (regWriteIdx == idx)) begin
            return regWriteData;
        end
        return fileVal;
    endfunction

    always_comb begin
        valA = bypass(idxA, dxRegA);
        valB = bypass(idxB, dxRegB);
    end

    // Operands
    assign immExt = {{(dataWidth-17){dxInstr.iView.immediate[16]}}, dxInstr.iView.immediate};

    // blt tests rd < rs, so swap
    assign opA = isBlt ? valB : valA;
    assign opB = isBlt ? valA : (isImm ? immExt : valB);

    // Only R-type carries its own function code, branches compare by subtracting
    always_comb begin
        if (opcode == opR) begin
            aluOpSel = dxInstr.rView.aluOp;
        end else if (opcode inside {opBne, opBlt}) begin
            aluOpSel = aluSub;
        end else begin
            aluOpSel = aluAdd;
        end
    end

    aluUnit alu (
        .operandA (opA),
        .operandB (opB),
        .aluOp    (aluOpSel),
        .shamt    (dxInstr.rView.shamt),
        .result   (aluResult),
        .notEqual (notEqual),
        .lessThan (lessThan)
    );

    ////////////////////////////////////////
    // Control flow
    ////////////////////////////////////////

    // dxPcNext is already PC+1
    assign branchTarget = dxPcNext + immExt;
    assign jumpTarget   = {{(dataWidth-27){1'b0}}, dxInstr.jView.target};

    assign takeBranch = ((opcode == opBne) && notEqual) || (isBlt && lessThan);
    assign redirect   = takeBranch || (opcode inside {opJ, opJal, opJr});

    always_comb begin
        if (takeBranch) begin
            redirectPc = branchTarget;
        end else if (opcode == opJr) begin
            // jr target is the bypassed rd
            redirectPc = valB;
        end else begin
            redirectPc = jumpTarget;
        end
    end

    // XM latch
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            xmInstr <= nopWord;
        end else begin
            xmInstr <= dxInstr;
        end
    end

    // jal result is its return address
    always_ff @(posedge clock) begin
        xmResult    <= (opcode == opJal) ? dxPcNext : aluResult;
        xmStoreData <= valB;
    end

endmodule

`default_nettype wire

//--- logic/fetchStage.sv
/* Fetch stage: PC register, next-PC selection and the FD latch */
`timescale 1ns/1ps
`default_nettype none

module fetchStage
    import isaPkg::*, coreCfgPkg::*;
(
    input  logic                     clock,
    input  logic                     rstN,
    input  logic [dataWidth-1:0]     imemData,
    input  logic                     loadUseHold,
    input  logic                     redirect,
    input  logic [dataWidth-1:0]     redirectPc,
    output logic [imemAddrWidth-1:0] imemAddr,
    output instrWordU                fdInstr,
    output logic [dataWidth-1:0]     fdPcNext
);

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcPlusOne;

    assign pcPlusOne = pc + dataWidth'(1);

    // Memory sees only the low address bits and reads combinationally
    assign imemAddr = pc[imemAddrWidth-1:0];

    // Redirect wins over hold
    // Squashed fetch turns into a bubble in FD
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc      <= resetPc;
            fdInstr <= nopWord;
        end else if (redirect) begin
            pc      <= redirectPc;
            fdInstr <= nopWord;
        end else if (!loadUseHold) begin
            pc      <= pcPlusOne;
            fdInstr <= imemData;
        end
    end

    // PC+1 travels with the instruction for branches and jal
    always_ff @(posedge clock) begin
        if (!loadUseHold) begin
            fdPcNext <= pcPlusOne;
        end
    end

endmodule

`default_nettype wire

//--- logic/isaPkg.sv
/* ISA definitions: opcodes, ALU function codes, register numbers,
   the instruction word with its R/I/J views and small field helpers */
`default_nettype none

package isaPkg;

    // Primary opcodes, bits [31:27]
    localparam logic [4:0] opR    = 5'd0;
    localparam logic [4:0] opJ    = 5'd1;
    localparam logic [4:0] opBne  = 5'd2;
    localparam logic [4:0] opJal  = 5'd3;
    localparam logic [4:0] opJr   = 5'd4;
    localparam logic [4:0] opAddi = 5'd5;
    localparam logic [4:0] opBlt  = 5'd6;
    localparam logic [4:0] opSw   = 5'd7;
    localparam logic [4:0] opLw   = 5'd8;

    // R-type function codes, bits [6:2]
    localparam logic [4:0] aluAdd = 5'd0;
    localparam logic [4:0] aluSub = 5'd1;
    localparam logic [4:0] aluAnd = 5'd2;
    localparam logic [4:0] aluOr  = 5'd3;
    localparam logic [4:0] aluSll = 5'd4;
    localparam logic [4:0] aluSra = 5'd5;

    localparam logic [4:0] regZero = 5'd0;
    // jal link register
    localparam logic [4:0] regLink = 5'd31;

    ////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////

    typedef struct packed {
        logic [4:0] opcode;
        logic [4:0] rd;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] shamt;
        logic [4:0] aluOp;
        logic [1:0] spare;
    } rViewT;

    typedef struct packed {
        logic [4:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [16:0] immediate;
    } iViewT;

    typedef struct packed {
        logic [4:0]  opcode;
        logic [26:0] target;
    } jViewT;

    // Same 32 bits, decoded per instruction class
    typedef union packed {
        rViewT rView;
        iViewT iView;
        jViewT jView;
    } instrWordU;

    // add r0, r0, r0
    localparam instrWordU nopWord = '0;

    // Opcodes that write the register file in writeback
    function automatic logic writesReg(input logic [4:0] opcode);
        return opcode inside {opR, opAddi, opLw, opJal};
    endfunction

    // jal links into r31, everything else targets rd
    function automatic logic [4:0] destReg(input instrWordU instr);
        return (instr.rView.opcode == opJal) ? regLink : instr.rView.rd;
    endfunction

    // Second read port carries rd instead of rt
    function automatic logic readsRdAsB(input logic [4:0] opcode);
        return opcode inside {opBne, opJr, opBlt, opSw};
    endfunction

endpackage

`default_nettype wire

//--- logic/memWritebackStage.sv
/* Memory and writeback stages: store-data bypass, data memory port,
   the MW latch and register file write selection */
`timescale 1ns/1ps
`default_nettype none

module memWritebackStage
    import isaPkg::*, coreCfgPkg::*;
(
    input  logic                   clock,
    input  logic                   rstN,
    input  instrWordU              xmInstr,
    input  logic [dataWidth-1:0]   xmResult,
    input  logic [dataWidth-1:0]   xmStoreData,
    input  logic [dataWidth-1:0]   dmemReadData,
    output logic [dataWidth-1:0]   dmemAddr,
    output logic [dataWidth-1:0]   dmemWriteData,
    output logic                   dmemWriteEn,
    output logic                   regWriteEn,
    output logic [regIdxWidth-1:0] regWriteIdx,
    output logic [dataWidth-1:0]   regWriteData
);

    instrWordU              mwInstr;
    logic [dataWidth-1:0]   mwResult;
    logic [dataWidth-1:0]   mwLoadData;
    logic [regIdxWidth-1:0] mwDest;

    ////////////////////////////////////////
    // Memory access
    ////////////////////////////////////////

    // ALU result is the effective address
    assign dmemAddr    = xmResult;
    assign dmemWriteEn = (xmInstr.iView.opcode == opSw);

    // Producer one slot older is in writeback now, often a load
    assign dmemWriteData = (regWriteEn && (regWriteIdx == xmInstr.iView.rd)) ? regWriteData
                                                                              : xmStoreData;

    // MW latch
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            mwInstr <= nopWord;
        end else begin
            mwInstr <= xmInstr;
        end
    end

    // Read data captured here, memory read is combinational on the address
    always_ff @(posedge clock) begin
        mwResult   <= xmResult;
        mwLoadData <= dmemReadData;
    end

    ////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////

    // jal goes to r31
    assign mwDest = destReg(mwInstr);

    // r0 writes are dropped here
    assign regWriteEn   = writesReg(mwInstr.rView.opcode) && (mwDest != regZero);
    assign regWriteIdx  = mwDest;
    assign regWriteData = (mwInstr.rView.opcode == opLw) ? mwLoadData : mwResult;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the core regression with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module cpuCoreTb -f all.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "Regression passed" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

//--- verif/clockGen.sv
/* Testbench clock (8 ns period) and reset generator, reset held 10 cycles */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    input  logic resetReq,
    output logic clock,
    output logic rstN
);

    int holdCount;

    initial begin
        clock     = 1'b0;
        rstN      = 1'b0;
        holdCount = 10;
    end

    always #4 clock = ~clock;

    // A request restarts the 10-cycle reset window
    always @(posedge clock) begin
        if (resetReq) begin
            rstN      <= 1'b0;
            holdCount <= 10;
        end else if (holdCount > 1) begin
            holdCount <= holdCount - 1;
        end else begin
            holdCount <= 0;
            rstN      <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verif/cpuCoreProperties.sv
/* Concurrent assertions on core writeback, memory write and load-use hold,
   bound into every cpuCore instance */
`timescale 1ns/1ps
`default_nettype none

module cpuCoreProperties (
    input logic        clock,
    input logic        rstN,
    input logic        regWriteEn,
    input logic [4:0]  regWriteIdx,
    input logic        dmemWriteEn,
    input logic        loadUseHold,
    input logic [11:0] imemAddr
);

    // Failure count, read by the testbench at the end of the run
    int assertFails = 0;

    // r0 is never a writeback target
    noZeroWrite: assert property (@(posedge clock) disable iff (!rstN)
        regWriteEn |-> (regWriteIdx != 5'd0))
        else begin
            assertFails++;
            $error("register write to r0");
        end

    // Pipeline comes out of reset empty
    quietAfterReset: assert property (@(posedge clock)
        $rose(rstN) |-> (!regWriteEn && !dmemWriteEn))
        else begin
            assertFails++;
            $error("write enable high right after reset");
        end

    // Hold freezes the fetch address for one cycle
    holdKeepsPc: assert property (@(posedge clock) disable iff (!rstN)
        loadUseHold |=> $stable(imemAddr))
        else begin
            assertFails++;
            $error("fetch address moved during load-use hold");
        end

endmodule

bind cpuCore cpuCoreProperties props (
    .clock       (clock),
    .rstN        (rstN),
    .regWriteEn  (regWriteEn),
    .regWriteIdx (regWriteIdx),
    .dmemWriteEn (dmemWriteEn),
    .loadUseHold (loadUseHold),
    .imemAddr    (imemAddr)
);

`default_nettype wire

//--- verif/cpuCoreTb.sv
/* Core testbench: memory and register file models, directed program tests,
   error counting and the cycle timeout */
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;
    import isaPkg::*;

    localparam int cyclesPerTest = 60;
    // Five tests plus slack for the power-up reset
    localparam int cycleLimit = 5 * cyclesPerTest + 50;

    logic        clock;
    logic        rstN;
    logic        resetReq;
    logic [11:0] imemAddr;
    logic [31:0] imemData;
    logic [31:0] dmemAddr;
    logic [31:0] dmemWriteData;
    logic        dmemWriteEn;
    logic [31:0] dmemReadData;
    logic        regWriteEn;
    logic [4:0]  regWriteIdx;
    logic [31:0] regWriteData;
    logic [4:0]  regReadIdxA;
    logic [4:0]  regReadIdxB;
    logic [31:0] regReadDataA;
    logic [31:0] regReadDataB;

    logic [31:0] imem [0:4095];
    logic [31:0] dmem [0:1023];
    logic [31:0] regs [0:31];
    // Register values at program start
    logic [31:0] startRegs [0:31];

    int cycleCount = 0;
    int errorCount = 0;
    int checkCount = 0;

    clockGen clkGen (.resetReq(resetReq), .clock(clock), .rstN(rstN));

    cpuCore UUT (
        .clock(clock), .rstN(rstN),
        .imemAddr(imemAddr), .imemData(imemData),
        .dmemAddr(dmemAddr), .dmemWriteData(dmemWriteData),
        .dmemWriteEn(dmemWriteEn), .dmemReadData(dmemReadData),
        .regWriteEn(regWriteEn), .regWriteIdx(regWriteIdx),
        .regWriteData(regWriteData),
        .regReadIdxA(regReadIdxA), .regReadIdxB(regReadIdxB),
        .regReadDataA(regReadDataA), .regReadDataB(regReadDataB)
    );

    ////////////////////////////////////////
    // Memory and register file models
    ////////////////////////////////////////

    assign imemData     = imem[imemAddr];
    assign dmemReadData = dmem[dmemAddr[9:0]];

    // Write-first reads with r0 hardwired to zero
    always_comb begin
        regReadDataA = (regReadIdxA == 5'd0) ? 32'd0
                     : (regWriteEn && regWriteIdx == regReadIdxA) ? regWriteData
                     : regs[regReadIdxA];
        regReadDataB = (regReadIdxB == 5'd0) ? 32'd0
                     : (regWriteEn && regWriteIdx == regReadIdxB) ? regWriteData
                     : regs[regReadIdxB];
    end

    always @(posedge clock) begin
        if (regWriteEn) regs[regWriteIdx] <= regWriteData;
        if (dmemWriteEn) dmem[dmemAddr[9:0]] <= dmemWriteData;
    end

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run passed %0d cycles without finishing", cycleLimit);
            $display("Regression failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Encoding and checking helpers
    ////////////////////////////////////////

    function automatic logic [31:0] encodeR(logic [4:0] op, int rd, int rs, int rt, int sh);
        return {opR, rd[4:0], rs[4:0], rt[4:0], sh[4:0], op, 2'b00};
    endfunction

    function automatic logic [31:0] encodeI(logic [4:0] op, int rd, int rs, int imm);
        return {op, rd[4:0], rs[4:0], imm[16:0]};
    endfunction

    function automatic logic [31:0] encodeJ(logic [4:0] op, int target);
        return {op, target[26:0]};
    endfunction

    // Depends on every address bit
    function automatic logic [31:0] dmemFill(int addr);
        return (addr * 32'h9e3779b1) ^ 32'h5a5a0000;
    endfunction

    // Hold the core in reset while memories and registers are loaded
    task automatic beginTest(input logic [31:0] prog [$]);
        @(posedge clock);
        #1 resetReq = 1'b1;
        @(posedge clock);
        #1 resetReq = 1'b0;
        for (int i = 0; i < 4096; i++) imem[i[11:0]] = nopWord;
        for (int i = 0; i < prog.size(); i++) imem[i[11:0]] = prog[i];
        for (int i = 0; i < 1024; i++) dmem[i[9:0]] = dmemFill(i);
        for (int i = 0; i < 32; i++) begin
            regs[i[4:0]] = (i == 0) ? 32'd0 : $urandom;
            startRegs[i[4:0]] = regs[i[4:0]];
        end
        while (!rstN) @(posedge clock);
        #1;
    endtask

    task automatic runCycles(input int n);
        repeat (n) @(posedge clock);
        #1;
    endtask

    task automatic expectReg(input string name, input int idx, input logic [31:0] exp);
        checkCount++;
        if (regs[idx[4:0]] !== exp) begin
            errorCount++;
            $display("[FAIL] %0t: %s r%0d = %h, expected %h",
                     $time, name, idx, regs[idx[4:0]], exp);
        end
    endtask

    task automatic expectMem(input string name, input int addr, input logic [31:0] exp);
        checkCount++;
        if (dmem[addr[9:0]] !== exp) begin
            errorCount++;
            $display("[FAIL] %0t: %s dmem[%0d] = %h, expected %h",
                     $time, name, addr, dmem[addr[9:0]], exp);
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic testAluOps();
        logic [31:0] prog [$];
        prog = '{encodeR(aluAdd, 3, 1, 2, 0), encodeR(aluSub, 4, 1, 2, 0),
                 encodeR(aluAnd, 5, 1, 2, 0), encodeR(aluOr, 6, 1, 2, 0),
                 encodeR(aluSll, 7, 1, 0, 5), encodeR(aluSra, 8, 9, 0, 7),
                 encodeI(opAddi, 10, 1, -100), encodeI(opAddi, 11, 0, 1234)};
        beginTest(prog);
        // Negative source for the sign-fill check
        regs[9][31] = 1'b1;
        startRegs[9] = regs[9];
        runCycles(30);
        expectReg("add", 3, startRegs[1] + startRegs[2]);
        expectReg("sub", 4, startRegs[1] - startRegs[2]);
        expectReg("and", 5, startRegs[1] & startRegs[2]);
        expectReg("or", 6, startRegs[1] | startRegs[2]);
        expectReg("sll", 7, {startRegs[1][26:0], 5'b00000});
        expectReg("sra", 8, {{7{startRegs[9][31]}}, startRegs[9][31:7]});
        expectReg("addi neg", 10, startRegs[1] - 32'd100);
        expectReg("addi", 11, 32'd1234);
    endtask

    task automatic testBypassChains();
        logic [31:0] prog [$];
        prog = '{encodeI(opAddi, 1, 0, 5), encodeI(opAddi, 2, 1, 7),
                 encodeR(aluAdd, 3, 2, 1, 0), encodeR(aluSub, 4, 1, 3, 0),
                 encodeR(aluAdd, 5, 4, 4, 0), encodeR(aluOr, 6, 5, 2, 0)};
        beginTest(prog);
        runCycles(30);
        expectReg("chain", 1, 32'd5);
        expectReg("chain", 2, 32'd12);
        expectReg("chain", 3, 32'd17);
        expectReg("chain", 4, 32'd5 - 32'd17);
        expectReg("chain", 5, 32'd0 - 32'd24);
        expectReg("chain", 6, (32'd0 - 32'd24) | 32'd12);
    endtask

    task automatic testLoadStore();
        logic [31:0] prog [$];
        prog = '{encodeI(opAddi, 1, 0, 16), encodeI(opLw, 2, 1, 4),
                 encodeR(aluAdd, 3, 2, 2, 0), encodeI(opAddi, 4, 0, 77),
                 encodeI(opSw, 4, 1, 0), encodeI(opLw, 5, 1, 0),
                 encodeI(opSw, 5, 1, 3), encodeI(opSw, 3, 0, 30)};
        beginTest(prog);
        runCycles(35);
        expectReg("lw", 2, dmemFill(20));
        expectReg("load-use", 3, dmemFill(20) + dmemFill(20));
        expectReg("lw after sw", 5, 32'd77);
        expectMem("sw", 16, 32'd77);
        expectMem("sw load data", 19, 32'd77);
        expectMem("sw", 30, dmemFill(20) + dmemFill(20));
        expectMem("untouched", 20, dmemFill(20));
    endtask

    task automatic testBranches();
        logic [31:0] prog [$];
        prog = '{encodeI(opAddi, 1, 0, 3), encodeI(opAddi, 2, 0, -2),
                 encodeI(opBne, 1, 2, 2), encodeI(opAddi, 10, 0, 1),
                 encodeI(opAddi, 11, 0, 1), encodeI(opBlt, 1, 2, 3),
                 encodeI(opAddi, 12, 0, 6), encodeI(opBlt, 2, 1, 2),
                 encodeI(opAddi, 13, 0, 1), encodeI(opAddi, 14, 0, 1),
                 encodeI(opBne, 1, 1, 5), encodeI(opAddi, 15, 0, 11)};
        beginTest(prog);
        runCycles(35);
        expectReg("bne squash", 10, startRegs[10]);
        expectReg("bne squash", 11, startRegs[11]);
        expectReg("blt not taken", 12, 32'd6);
        expectReg("blt squash", 13, startRegs[13]);
        expectReg("blt squash", 14, startRegs[14]);
        expectReg("bne not taken", 15, 32'd11);
    endtask

    task automatic testJumps();
        logic [31:0] prog [$];
        prog = '{encodeI(opAddi, 1, 0, 20), encodeJ(opJ, 4),
                 encodeI(opAddi, 10, 0, 1), encodeI(opAddi, 11, 0, 1),
                 encodeJ(opJal, 8), encodeI(opAddi, 12, 0, 1),
                 encodeI(opAddi, 13, 0, 1), encodeI(opAddi, 14, 0, 1),
                 encodeI(opAddi, 2, 0, 9), encodeI(opJr, 1, 0, 0),
                 encodeI(opAddi, 15, 0, 1), encodeI(opAddi, 16, 0, 1)};
        beginTest(prog);
        imem[20] = encodeI(opAddi, 3, 31, 100);
        // Spin at the end
        imem[21] = encodeJ(opJ, 21);
        runCycles(35);
        expectReg("jal link", 31, 32'd5);
        expectReg("jal target", 2, 32'd9);
        expectReg("jr target", 3, 32'd105);
        for (int i = 10; i <= 16; i++) expectReg("jump squash", i, startRegs[i[4:0]]);
    endtask

    initial begin
        resetReq = 1'b0;
        void'($urandom(32'ha9cb));
        testAluOps();
        testBypassChains();
        testLoadStore();
        testBranches();
        testJumps();
        errorCount += UUT.props.assertFails;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, UUT.props.assertFails);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
